// ==== include/spi_loader_consts.svh ====
// Loader sizing macros: address counter width and RAM depths

`ifndef SPI_LOADER_CONSTS_SVH
`define SPI_LOADER_CONSTS_SVH

// Byte address counter width, also sets the RAM word index width
`define LOADER_XLEN 32

// Instruction RAM depth in 32-bit words
`define IRAM_WORDS 256

// Data RAM depth in 32-bit words
`define DRAM_WORDS 128

`endif

// ==== rtl/loader_cmd_pkg.sv ====
// Host command opcodes, received SPI byte and loader control state types

`default_nettype none

package loader_cmd_pkg;

typedef enum logic [7:0] {
    CMD_CPU_RST = 8'h2a,
    CMD_CPU_RUN = 8'h2b,
    CMD_IRAM_WR = 8'h2c,
    CMD_IRAM_RD = 8'h2d,
    CMD_DRAM_WR = 8'h2e,
    CMD_DRAM_RD = 8'h2f
} loader_cmd_t;

typedef struct packed {
    logic [7:0] data;
    logic       dc;     // Low for a command, high for a data byte
} spi_byte_t;

// Core reset level and the four RAM selects, at most one select is set
typedef struct packed {
    logic cpu_rst_n;
    logic iram_wr_sel;
    logic iram_rd_sel;
    logic dram_wr_sel;
    logic dram_rd_sel;
} loader_ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/ram_bus_pkg.sv ====
// RAM request type shared by the command decoder and the memories

`default_nettype none

`include "spi_loader_consts.svh"

package ram_bus_pkg;

typedef struct packed {
    logic                      wr_en;
    logic [3:0]                byte_en;   // One lane per byte of the word
    logic [`LOADER_XLEN-3:0]   word_addr;
    logic [31:0]               wdata;     // Same byte on all four lanes
} ram_req_t;

endpackage

`default_nettype wire

// ==== rtl/spi_byte_rx.sv ====
// SPI mode-0 slave: pin synchronisers, byte receiver and reply shift register

`timescale 1ns/10ps
`default_nettype none

module spi_byte_rx import loader_cmd_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       spi_sclk_i,
    input  logic       spi_cs_n_i,
    input  logic       spi_mosi_i,
    input  logic       spi_dc_i,

    input  logic [7:0] tx_byte_i,

    output logic       rx_vld_o,
    output spi_byte_t  rx_byte_o,
    output logic       spi_miso_o
);

typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
    logic dc;
} spi_pins_t;

localparam spi_pins_t PINS_IDLE = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0, dc: 1'b0};

spi_pins_t pins_meta;
spi_pins_t pins_sync;

logic sclk_q;
logic cs_n_q;
logic sclk_rise;
logic sclk_fall;
logic cs_fall;

logic [2:0] bit_cnt;
logic [6:0] rx_shift;
logic [1:0] vld_pipe;
logic [7:0] tx_shift;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        pins_meta <= PINS_IDLE;
        pins_sync <= PINS_IDLE;
        sclk_q    <= 1'b0;
        cs_n_q    <= 1'b1;
    end else begin
        pins_meta <= '{sclk: spi_sclk_i, cs_n: spi_cs_n_i, mosi: spi_mosi_i, dc: spi_dc_i};
        pins_sync <= pins_meta;
        sclk_q    <= pins_sync.sclk;
        cs_n_q    <= pins_sync.cs_n;
    end
end

assign sclk_rise = pins_sync.sclk & ~sclk_q;
assign sclk_fall = ~pins_sync.sclk & sclk_q;
assign cs_fall   = ~pins_sync.cs_n & cs_n_q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        bit_cnt  <= 3'd0;
        rx_vld_o <= 1'b0;
    end else begin
        rx_vld_o <= 1'b0;
        if (pins_sync.cs_n) begin
            bit_cnt <= 3'd0;
        end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            rx_vld_o <= (bit_cnt == 3'd7);  // Eighth bit completes the byte
        end
    end
end

always_ff @(posedge clk_i) begin
    if (!pins_sync.cs_n && sclk_rise) begin
        rx_shift <= {rx_shift[5:0], pins_sync.mosi};
        if (bit_cnt == 3'd7) begin
            rx_byte_o <= '{data: {rx_shift, pins_sync.mosi}, dc: pins_sync.dc};
        end
    end
end

// The reply byte is ready two cycles after the strobe, once the RAM read has settled
always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        vld_pipe <= 2'b00;
        tx_shift <= 8'h00;
    end else begin
        vld_pipe <= {vld_pipe[0], rx_vld_o};
        if (vld_pipe[1] || cs_fall) begin
            tx_shift <= tx_byte_i;
        end else if (sclk_fall && bit_cnt != 3'd0) begin  // Trailing edge of bit 7 is skipped
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end
end

assign spi_miso_o = tx_shift[7];

endmodule

`default_nettype wire

// ==== rtl/ram_rw.sv ====
// Command decoder, byte address walker and read-back byte selector

`timescale 1ns/10ps
`default_nettype none

`include "spi_loader_consts.svh"

module ram_rw import loader_cmd_pkg::*, ram_bus_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  logic        rx_vld_i,
    input  spi_byte_t   rx_byte_i,

    input  logic [31:0] iram_rdata_i,
    input  logic [31:0] dram_rdata_i,

    output logic        cpu_rst_n_o,

    output ram_req_t    iram_req_o,
    output ram_req_t    dram_req_o,

    output logic [7:0]  tx_byte_o
);

loader_ctrl_t ctrl;
loader_ctrl_t cmd_ctrl;

logic [`LOADER_XLEN-1:0] byte_addr;
logic [3:0]              byte_en;

logic        data_stb;
logic [31:0] rd_word;

// Every command holds the core in reset except CMD_CPU_RUN
always_comb begin
    cmd_ctrl = '0;
    case (loader_cmd_t'(rx_byte_i.data))
        CMD_CPU_RUN: cmd_ctrl.cpu_rst_n   = 1'b1;
        CMD_IRAM_WR: cmd_ctrl.iram_wr_sel = 1'b1;
        CMD_IRAM_RD: cmd_ctrl.iram_rd_sel = 1'b1;
        CMD_DRAM_WR: cmd_ctrl.dram_wr_sel = 1'b1;
        CMD_DRAM_RD: cmd_ctrl.dram_rd_sel = 1'b1;
        default: ;  // CMD_CPU_RST and unknown codes deselect both RAMs
    endcase
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        ctrl      <= '0;
        byte_addr <= '0;
        byte_en   <= 4'b0001;
    end else if (rx_vld_i) begin
        if (!rx_byte_i.dc) begin
            ctrl      <= cmd_ctrl;
            byte_addr <= '0;
            byte_en   <= 4'b0001;
        end else if (!ctrl.cpu_rst_n) begin
            byte_addr <= byte_addr + 1'b1;
            byte_en   <= {byte_en[2:0], byte_en[3]};  // Lane follows the low address bits
        end
    end
end

assign cpu_rst_n_o = ctrl.cpu_rst_n;

// Data bytes only reach memory while the core is held in reset
assign data_stb = rx_vld_i & rx_byte_i.dc & ~ctrl.cpu_rst_n;

assign iram_req_o = '{
    wr_en:     data_stb & ctrl.iram_wr_sel,
    byte_en:   byte_en,
    word_addr: byte_addr[`LOADER_XLEN-1:2],
    wdata:     {4{rx_byte_i.data}}
};

assign dram_req_o = '{
    wr_en:     data_stb & ctrl.dram_wr_sel,
    byte_en:   byte_en,
    word_addr: byte_addr[`LOADER_XLEN-1:2],
    wdata:     {4{rx_byte_i.data}}
};

always_comb begin
    if (ctrl.iram_rd_sel) begin
        rd_word = iram_rdata_i;
    end else if (ctrl.dram_rd_sel) begin
        rd_word = dram_rdata_i;
    end else begin
        rd_word = 32'h0000_0000;
    end
end

// Valid one cycle after the address moves, the RAM read is registered
assign tx_byte_o = rd_word[byte_addr[1:0]*8 +: 8];

endmodule

`default_nettype wire

// ==== rtl/byte_ram.sv ====
// Word-wide synchronous RAM with per-byte write enables and registered read

`timescale 1ns/10ps
`default_nettype none

module byte_ram import ram_bus_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  logic        clk_i,
    input  ram_req_t    req_i,
    output logic [31:0] rdata_o
);

localparam int AW = $clog2(DEPTH);

logic [31:0]   mem [DEPTH];
logic [AW-1:0] word_idx;

assign word_idx = req_i.word_addr[AW-1:0];  // Depth is a power of two, so this wraps

always_ff @(posedge clk_i) begin
    for (int lane = 0; lane < 4; lane++) begin
        if (req_i.wr_en && req_i.byte_en[lane]) begin
            mem[word_idx][lane*8 +: 8] <= req_i.wdata[lane*8 +: 8];
        end
    end
    rdata_o <= mem[word_idx];  // Old data on a write to the same word
end

endmodule

`default_nettype wire

// ==== rtl/spi_loader_top.sv ====
// SPI boot loader top level: byte receiver, command decoder and two RAMs

`timescale 1ns/10ps
`default_nettype none

`include "spi_loader_consts.svh"

module spi_loader_top import loader_cmd_pkg::*, ram_bus_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,

    input  logic spi_sclk_i,
    input  logic spi_cs_n_i,
    input  logic spi_mosi_i,
    input  logic spi_dc_i,

    output logic spi_miso_o,
    output logic cpu_rst_n_o
);

logic      rx_vld;
spi_byte_t rx_byte;

logic [7:0] tx_byte;

ram_req_t iram_req;
ram_req_t dram_req;

logic [31:0] iram_rdata;
logic [31:0] dram_rdata;

spi_byte_rx spi_byte_rx_u (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .spi_sclk_i (spi_sclk_i),
    .spi_cs_n_i (spi_cs_n_i),
    .spi_mosi_i (spi_mosi_i),
    .spi_dc_i   (spi_dc_i),
    .tx_byte_i  (tx_byte),
    .rx_vld_o   (rx_vld),
    .rx_byte_o  (rx_byte),
    .spi_miso_o (spi_miso_o)
);

ram_rw ram_rw_u (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rx_vld_i     (rx_vld),
    .rx_byte_i    (rx_byte),
    .iram_rdata_i (iram_rdata),
    .dram_rdata_i (dram_rdata),
    .cpu_rst_n_o  (cpu_rst_n_o),
    .iram_req_o   (iram_req),
    .dram_req_o   (dram_req),
    .tx_byte_o    (tx_byte)
);

byte_ram #(
    .DEPTH (`IRAM_WORDS)
) iram_u (
    .clk_i   (clk_i),
    .req_i   (iram_req),
    .rdata_o (iram_rdata)
);

byte_ram #(
    .DEPTH (`DRAM_WORDS)
) dram_u (
    .clk_i   (clk_i),
    .req_i   (dram_req),
    .rdata_o (dram_rdata)
);

endmodule

`default_nettype wire

// ==== sim/spi_loader_sva.sv ====
// Concurrent assertions on the command decoder's selects and RAM write requests, and their bind

`timescale 1ns/10ps
`default_nettype none

module spi_loader_sva import loader_cmd_pkg::*, ram_bus_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  loader_ctrl_t ctrl_i,
    input  logic         cpu_rst_n_i,
    input  ram_req_t     iram_req_i,
    input  ram_req_t     dram_req_i
);

// Only one RAM path may be selected at a time
sel_one_hot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({ctrl_i.iram_wr_sel, ctrl_i.iram_rd_sel, ctrl_i.dram_wr_sel, ctrl_i.dram_rd_sel}))
    else $error("More than one RAM select is high");

iram_lane_one_hot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    iram_req_i.wr_en |-> $onehot(iram_req_i.byte_en))
    else $error("Instruction RAM write without a single byte lane");

dram_lane_one_hot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dram_req_i.wr_en |-> $onehot(dram_req_i.byte_en))
    else $error("Data RAM write without a single byte lane");

// Memory is frozen once the core runs
no_write_while_running: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cpu_rst_n_i |-> !(iram_req_i.wr_en || dram_req_i.wr_en))
    else $error("RAM write request while the core is out of reset");

endmodule

bind ram_rw spi_loader_sva decoder_checks_u (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ctrl_i      (ctrl),
    .cpu_rst_n_i (cpu_rst_n_o),
    .iram_req_i  (iram_req_o),
    .dram_req_i  (dram_req_o)
);

`default_nettype wire

// ==== sim/spi_loader_tb.sv ====
// Testbench for the SPI boot loader: SPI host task, reference RAM model and stimulus table

`timescale 1ns/10ps
`default_nettype none

`include "spi_loader_consts.svh"

module spi_loader_tb import loader_cmd_pkg::*; ();

localparam int CLK_PERIOD   = 4;
localparam int SCLK_HALF    = 4;
localparam int IDLE_CYCLES  = 16;
localparam int FRAME_CYCLES = 1 + 16 * SCLK_HALF + SCLK_HALF + IDLE_CYCLES;
localparam int N_ROWS       = 11;
localparam int IRAM_BYTES   = `IRAM_WORDS * 4;
localparam int DRAM_BYTES   = `DRAM_WORDS * 4;

typedef struct packed {
    logic [7:0]  cmd;
    logic [15:0] count;      // Data frames after the command
    logic        rand_fill;  // Random data bytes, else zero dummies
} stim_row_t;

stim_row_t rows [N_ROWS] = '{
    '{cmd: CMD_IRAM_WR, count: 16'd12,  rand_fill: 1'b1},
    '{cmd: CMD_IRAM_RD, count: 16'd12,  rand_fill: 1'b0},
    '{cmd: CMD_DRAM_WR, count: 16'd16,  rand_fill: 1'b1},
    '{cmd: CMD_IRAM_RD, count: 16'd12,  rand_fill: 1'b0},
    '{cmd: CMD_DRAM_RD, count: 16'd16,  rand_fill: 1'b0},
    '{cmd: CMD_CPU_RUN, count: 16'd6,   rand_fill: 1'b1},  // Core running, data is ignored
    '{cmd: CMD_IRAM_RD, count: 16'd12,  rand_fill: 1'b0},
    '{cmd: 8'h55,       count: 16'd8,   rand_fill: 1'b1},  // Unknown opcode
    '{cmd: CMD_IRAM_RD, count: 16'd12,  rand_fill: 1'b0},
    '{cmd: CMD_DRAM_WR, count: 16'd600, rand_fill: 1'b1},  // Wraps past 512 bytes
    '{cmd: CMD_DRAM_RD, count: 16'd520, rand_fill: 1'b0}
};

logic clk_i;
logic rst_n_i;
logic spi_sclk;
logic spi_cs_n;
logic spi_mosi;
logic spi_dc;
logic spi_miso;
logic cpu_rst_n;

// Reference model of the loader state and both memories
logic [7:0]  iram_model [IRAM_BYTES];
logic [7:0]  dram_model [DRAM_BYTES];
bit          iram_known [IRAM_BYTES];
bit          dram_known [DRAM_BYTES];
logic        model_held;
logic        model_iram_wr;
logic        model_iram_rd;
logic        model_dram_wr;
logic        model_dram_rd;
int unsigned model_addr;

int     errors;
int     checks;
integer seed;

spi_loader_top spi_loader_top_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .spi_sclk_i  (spi_sclk),
    .spi_cs_n_i  (spi_cs_n),
    .spi_mosi_i  (spi_mosi),
    .spi_dc_i    (spi_dc),
    .spi_miso_o  (spi_miso),
    .cpu_rst_n_o (cpu_rst_n)
);

always #(CLK_PERIOD / 2) clk_i = ~clk_i;

function automatic longint total_frames();
    longint frames;
    frames = 1;  // The frame sent before any command
    for (int r = 0; r < N_ROWS; r++) begin
        frames += rows[r].count + 1;
    end
    return frames;
endfunction

// One mode-0 frame, MSB first; MISO is taken while SCLK is high
task automatic send_frame(input logic dc, input logic [7:0] tx, output logic [7:0] rx);
    int bit_idx;
    @(posedge clk_i);
    spi_cs_n <= 1'b0;
    spi_dc   <= dc;
    for (bit_idx = 7; bit_idx >= 0; bit_idx--) begin
        spi_mosi <= tx[bit_idx];
        repeat (SCLK_HALF) @(posedge clk_i);
        spi_sclk <= 1'b1;
        @(negedge clk_i);
        rx[bit_idx] = spi_miso;
        repeat (SCLK_HALF) @(posedge clk_i);
        spi_sclk <= 1'b0;
    end
    repeat (SCLK_HALF) @(posedge clk_i);
    spi_cs_n <= 1'b1;
    repeat (IDLE_CYCLES) @(posedge clk_i);
endtask

// Reply shifted out during the next frame: the byte at the current address of the read RAM
task automatic predict_reply(output logic [7:0] value, output bit known);
    value = 8'h00;
    known = 1'b1;
    if (model_iram_rd) begin
        value = iram_model[model_addr % IRAM_BYTES];
        known = iram_known[model_addr % IRAM_BYTES];
    end else if (model_dram_rd) begin
        value = dram_model[model_addr % DRAM_BYTES];
        known = dram_known[model_addr % DRAM_BYTES];
    end
endtask

task automatic update_model(input logic dc, input logic [7:0] data);
    if (!dc) begin
        model_held    = (data != CMD_CPU_RUN);
        model_iram_wr = (data == CMD_IRAM_WR);
        model_iram_rd = (data == CMD_IRAM_RD);
        model_dram_wr = (data == CMD_DRAM_WR);
        model_dram_rd = (data == CMD_DRAM_RD);
        model_addr    = 0;
    end else if (model_held) begin
        if (model_iram_wr) begin
            iram_model[model_addr % IRAM_BYTES] = data;
            iram_known[model_addr % IRAM_BYTES] = 1'b1;
        end
        if (model_dram_wr) begin
            dram_model[model_addr % DRAM_BYTES] = data;
            dram_known[model_addr % DRAM_BYTES] = 1'b1;
        end
        model_addr++;
    end
endtask

task automatic run_frame(input logic dc, input logic [7:0] data);
    logic [7:0] expected;
    logic [7:0] reply;
    bit         known;
    predict_reply(expected, known);
    send_frame(dc, data, reply);
    update_model(dc, data);
    if (known) begin
        checks++;
        assert (reply === expected) else begin
            $display("Mismatch at %0t: MISO gave 0x%02h for byte 0x%02h (dc %b), expected 0x%02h",
                     $time, reply, data, dc, expected);
            errors++;
        end
    end
    checks++;
    assert (cpu_rst_n === !model_held) else begin
        $display("Mismatch at %0t: cpu_rst_n_o is %b after byte 0x%02h, expected %b",
                 $time, cpu_rst_n, data, !model_held);
        errors++;
    end
endtask

initial begin
    longint limit_ns;
    limit_ns = (total_frames() * FRAME_CYCLES + 200) * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: stimulus did not finish");
    $display("RESULT: FAIL");
    $finish;
end

initial begin
    int         row;
    int         beat;
    logic [7:0] fill;
    clk_i    = 1'b0;
    rst_n_i  = 1'b0;
    spi_sclk = 1'b0;
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    spi_dc   = 1'b0;
    errors   = 0;
    checks   = 0;
    seed     = 32'h7369;
    model_held    = 1'b1;  // Core starts in reset with nothing selected
    model_iram_wr = 1'b0;
    model_iram_rd = 1'b0;
    model_dram_wr = 1'b0;
    model_dram_rd = 1'b0;
    model_addr    = 0;
    for (int i = 0; i < IRAM_BYTES; i++) begin
        iram_model[i] = 8'h00;
        iram_known[i] = 1'b0;
    end
    for (int i = 0; i < DRAM_BYTES; i++) begin
        dram_model[i] = 8'h00;
        dram_known[i] = 1'b0;
    end

    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (4) @(posedge clk_i);

    checks++;
    assert (cpu_rst_n === 1'b0) else begin
        $display("Mismatch at %0t: cpu_rst_n_o is %b after reset, expected 0", $time, cpu_rst_n);
        errors++;
    end
    run_frame(1'b1, 8'ha5);  // No command yet, so the reply is zero

    for (row = 0; row < N_ROWS; row++) begin
        run_frame(1'b0, rows[row].cmd);
        for (beat = 0; beat < int'(rows[row].count); beat++) begin
            fill = rows[row].rand_fill ? 8'($random(seed)) : 8'h00;
            run_frame(1'b1, fill);
        end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("RESULT: PASS");
    end else begin
        $display("RESULT: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== spi_loader_top.f ====
+incdir+include
rtl/loader_cmd_pkg.sv
rtl/ram_bus_pkg.sv
rtl/spi_byte_rx.sv
rtl/ram_rw.sv
rtl/byte_ram.sv
rtl/spi_loader_top.sv
sim/spi_loader_sva.sv
sim/spi_loader_tb.sv

// ==== Makefile ====
# Verilator simulation of the SPI boot loader

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module spi_loader_tb \
		-f spi_loader_top.f -Mdir obj_dir
	./obj_dir/Vspi_loader_tb 2>&1 | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)
	! grep -q "RESULT: FAIL" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
